/* logic/fetch_settings.svh */
`ifndef FETCH_SETTINGS_SVH
`define FETCH_SETTINGS_SVH

////////////////////////////////////////
// datapath
////////////////////////////////////////

// address and instruction width
`define FETCH_XLEN 32

// block pc after reset
`define FETCH_RESET_PC 32'h0000_0000

////////////////////////////////////////
// icache geometry
////////////////////////////////////////

// one 64-bit block per line holding two instructions
`define ICACHE_LINES 32
// index comes from pc[7:3]
`define ICACHE_IDX_W 5
// tag comes from pc[15:8] so addresses stay within 16 bits
`define ICACHE_TAG_W 8

// memory transaction tag where zero means busy
`define MEM_TAG_W 4

`endif

/* logic/fetch_pkg.sv */
`include "fetch_settings.svh"

package fetch_pkg;

    ////////////////////////////////////////
    // memory side
    ////////////////////////////////////////

    // command to memory
    typedef enum logic [1:0] {
        NONE = 2'h0,
        LOAD = 2'h1
    } mem_cmd_e;

    // outgoing request with block-aligned address
    typedef struct packed {
        mem_cmd_e                cmd;
        logic [`FETCH_XLEN-1:0]  addr;
    } mem_req_t;

    // response tag accepts the command
    // data tag marks the later beat
    typedef struct packed {
        logic [`MEM_TAG_W-1:0]   response;
        logic [`MEM_TAG_W-1:0]   tag;
        logic [63:0]             data;
    } mem_rsp_t;

    ////////////////////////////////////////
    // fetch side
    ////////////////////////////////////////

    // inst[0] is the lower address
    typedef struct packed {
        logic                          valid;
        logic [`FETCH_XLEN-1:0]        pc;
        logic [1:0][`FETCH_XLEN-1:0]   inst;
    } fetch_block_t;

    // target is 8-byte aligned
    typedef struct packed {
        logic                    valid;
        logic [`FETCH_XLEN-1:0]  target;
    } redirect_t;

    // array write from the controller
    typedef struct packed {
        logic                       en;
        logic [`ICACHE_IDX_W-1:0]   idx;
        logic [`ICACHE_TAG_W-1:0]   tag;
        logic [63:0]                data;
    } icache_fill_t;

endpackage

/* logic/icache_mem.sv */
`timescale 1ns/1ps
`include "fetch_settings.svh"

module icache_mem (
    input  logic                      clock,
    input  logic                      arst_n,
    input  fetch_pkg::icache_fill_t   fill,
    input  logic [`ICACHE_IDX_W-1:0]  rd_idx,
    output logic                      rd_valid,
    output logic [`ICACHE_TAG_W-1:0]  rd_tag,
    output logic [63:0]               rd_data
);

    // one valid bit per line
    logic [`ICACHE_LINES-1:0]  line_valid;
    // tag and block storage
    logic [`ICACHE_TAG_W-1:0]  line_tag  [`ICACHE_LINES];
    logic [63:0]               line_data [`ICACHE_LINES];

    ////////////////////////////////////////
    // write side
    ////////////////////////////////////////

    // valid bits clear on reset
    // set on fill
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            line_valid <= '0;
        end else if (fill.en) begin
            line_valid[fill.idx] <= 1'b1;
        end
    end

    // tag and data land at the edge after the tagged beat
    always_ff @(posedge clock) begin
        if (fill.en) begin
            line_tag[fill.idx]  <= fill.tag;
            line_data[fill.idx] <= fill.data;
        end
    end

    ////////////////////////////////////////
    // read side
    ////////////////////////////////////////

    // combinational lookup by index
    // no bypass of a fill in the same cycle
    assign rd_valid = line_valid[rd_idx];
    assign rd_tag   = line_tag[rd_idx];
    assign rd_data  = line_data[rd_idx];

endmodule

/* logic/icache_ctrl.sv */
`timescale 1ns/1ps
`include "fetch_settings.svh"

module icache_ctrl (
    input  logic                      clock,
    input  logic                      arst_n,
    input  logic [`FETCH_XLEN-1:0]    fetch_pc,
    input  logic                      rd_valid,
    input  logic [`ICACHE_TAG_W-1:0]  rd_tag,
    input  logic [63:0]               rd_data,
    input  fetch_pkg::mem_rsp_t       mem_rsp,
    output logic [`ICACHE_IDX_W-1:0]  rd_idx,
    output logic                      hit,
    output logic [63:0]               block_data,
    output fetch_pkg::icache_fill_t   fill,
    output fetch_pkg::mem_req_t       mem_req
);

    import fetch_pkg::*;

    // tag field of the current pc
    logic [`ICACHE_TAG_W-1:0]  pc_tag;

    // outstanding miss
    logic                      pending;
    logic [`MEM_TAG_W-1:0]     pend_rsp_tag;
    logic [`ICACHE_IDX_W-1:0]  pend_idx;
    logic [`ICACHE_TAG_W-1:0]  pend_tag;

    // handshake events
    logic                      req_load;
    logic                      accepted;
    logic                      returned;

    ////////////////////////////////////////
    // lookup
    ////////////////////////////////////////

    // index pc[7:3] and tag pc[15:8]
    assign rd_idx     = fetch_pc[3 +: `ICACHE_IDX_W];
    assign pc_tag     = fetch_pc[3 + `ICACHE_IDX_W +: `ICACHE_TAG_W];
    assign hit        = rd_valid && (rd_tag == pc_tag);
    assign block_data = rd_data;

    ////////////////////////////////////////
    // memory handshake
    ////////////////////////////////////////

    // only one miss in flight
    // keep asking while the response tag is zero
    assign req_load = !hit && !pending;
    assign accepted = req_load && (mem_rsp.response != '0);
    // data beat carries the saved response tag
    assign returned = pending && (mem_rsp.tag == pend_rsp_tag);

    always_comb begin
        mem_req.cmd  = req_load ? LOAD : NONE;
        // block aligned
        mem_req.addr = {fetch_pc[`FETCH_XLEN-1:3], 3'b000};
    end

    // pending flag
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            pending <= 1'b0;
        end else if (accepted) begin
            pending <= 1'b1;
        end else if (returned) begin
            pending <= 1'b0;
        end
    end

    // miss bookkeeping
    // captured when memory takes the command
    always_ff @(posedge clock) begin
        if (accepted) begin
            pend_rsp_tag <= mem_rsp.response;
            pend_idx     <= rd_idx;
            pend_tag     <= pc_tag;
        end
    end

    ////////////////////////////////////////
    // fill
    ////////////////////////////////////////

    // completes even if the pc moved on after a redirect
    always_comb begin
        fill.en   = returned;
        fill.idx  = pend_idx;
        fill.tag  = pend_tag;
        fill.data = mem_rsp.data;
    end

endmodule

/* logic/fetch_stage.sv */
`timescale 1ns/1ps
`include "fetch_settings.svh"

module fetch_stage (
    input  logic                     clock,
    input  logic                     arst_n,
    input  logic                     stall,
    input  fetch_pkg::redirect_t     redirect,
    input  logic                     hit,
    input  logic [63:0]              block_data,
    output logic [`FETCH_XLEN-1:0]   fetch_pc,
    output fetch_pkg::fetch_block_t  fetch_block
);

    // block pc
    logic [`FETCH_XLEN-1:0]  pc_q;
    logic [`FETCH_XLEN-1:0]  pc_next;
    // block gets registered at this edge
    logic                    take;

    // output register
    logic                    out_valid;
    logic [`FETCH_XLEN-1:0]  out_pc;
    logic [63:0]             out_data;

    ////////////////////////////////////////
    // next pc
    ////////////////////////////////////////

    assign take = hit && !stall && !redirect.valid;

    // redirect wins over stall and advance
    always_comb begin
        if (redirect.valid) begin
            pc_next = redirect.target;
        end else if (take) begin
            pc_next = pc_q + `FETCH_XLEN'(8);
        end else begin
            pc_next = pc_q;
        end
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            pc_q <= `FETCH_RESET_PC;
        end else begin
            pc_q <= pc_next;
        end
    end

    ////////////////////////////////////////
    // fetch block register
    ////////////////////////////////////////

    // redirect drops the undelivered packet
    // stall holds whatever is there
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
        end else if (redirect.valid) begin
            out_valid <= 1'b0;
        end else if (!stall) begin
            out_valid <= hit;
        end
    end

    always_ff @(posedge clock) begin
        if (take) begin
            out_pc   <= pc_q;
            out_data <= block_data;
        end
    end

    assign fetch_pc = pc_q;

    // lower word is the lower address
    always_comb begin
        fetch_block.valid   = out_valid;
        fetch_block.pc      = out_pc;
        fetch_block.inst[0] = out_data[31:0];
        fetch_block.inst[1] = out_data[63:32];
    end

endmodule

/* logic/fetch_top.sv */
`timescale 1ns/1ps
`include "fetch_settings.svh"

module fetch_top (
    input  logic                     clock,
    input  logic                     arst_n,
    input  logic                     stall,
    input  fetch_pkg::redirect_t     redirect,
    input  fetch_pkg::mem_rsp_t      mem_rsp,
    output fetch_pkg::mem_req_t      mem_req,
    output fetch_pkg::fetch_block_t  fetch_block
);

    import fetch_pkg::*;

    ////////////////////////////////////////
    // stage to controller
    ////////////////////////////////////////

    logic [`FETCH_XLEN-1:0]    fetch_pc;
    logic                      hit;
    logic [63:0]               block_data;

    ////////////////////////////////////////
    // controller to array
    ////////////////////////////////////////

    logic [`ICACHE_IDX_W-1:0]  rd_idx;
    logic                      rd_valid;
    logic [`ICACHE_TAG_W-1:0]  rd_tag;
    logic [63:0]               rd_data;
    icache_fill_t              fill;

    // pc register and output block
    fetch_stage u_fetch_stage (
        .clock       (clock),
        .arst_n      (arst_n),
        .stall       (stall),
        .redirect    (redirect),
        .hit         (hit),
        .block_data  (block_data),
        .fetch_pc    (fetch_pc),
        .fetch_block (fetch_block)
    );

    // hit check and miss handling
    icache_ctrl u_icache_ctrl (
        .clock      (clock),
        .arst_n     (arst_n),
        .fetch_pc   (fetch_pc),
        .rd_valid   (rd_valid),
        .rd_tag     (rd_tag),
        .rd_data    (rd_data),
        .mem_rsp    (mem_rsp),
        .rd_idx     (rd_idx),
        .hit        (hit),
        .block_data (block_data),
        .fill       (fill),
        .mem_req    (mem_req)
    );

    // direct-mapped storage
    icache_mem u_icache_mem (
        .clock    (clock),
        .arst_n   (arst_n),
        .fill     (fill),
        .rd_idx   (rd_idx),
        .rd_valid (rd_valid),
        .rd_tag   (rd_tag),
        .rd_data  (rd_data)
    );

endmodule

/* test/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clock,
    output logic arst_n
);

    // reset length in clock cycles
    localparam int reset_cycles = 8;

    // 40 ns period
    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    // release on a falling edge, away from the flops
    initial begin
        arst_n = 1'b0;
        repeat (reset_cycles) @(posedge clock);
        @(negedge clock);
        arst_n = 1'b1;
    end

endmodule

/* test/tb_mem_model.sv */
`timescale 1ns/1ps
`include "fetch_settings.svh"

module tb_mem_model (
    input  logic                 clock,
    input  logic                 arst_n,
    input  int                   busy_pct,
    input  fetch_pkg::mem_req_t  mem_req,
    output fetch_pkg::mem_rsp_t  mem_rsp,
    output int                   accept_count
);

    import fetch_pkg::*;

    // cycles from acceptance to the tagged data beat
    localparam int data_delay = 4;

    // reset as seen at the last rising edge
    logic live;

    // memory contents, same rule as the checker
    function automatic logic [`FETCH_XLEN-1:0] mem_word(input logic [`FETCH_XLEN-1:0] a);
        return a ^ 32'h1357_9bdf;
    endfunction

    always @(posedge clock) begin
        live <= arst_n;
    end

    ////////////////////////////////////////
    // handshake, driven on the falling edge
    ////////////////////////////////////////

    initial begin : responder
        integer                  seed;
        int                      rnd;
        int                      cycle;
        logic                    busy;
        logic [`MEM_TAG_W-1:0]   next_tag;
        logic [`MEM_TAG_W-1:0]   ret_tag  [$];
        logic [`FETCH_XLEN-1:0]  ret_addr [$];
        int                      ret_due  [$];
        mem_rsp_t                rsp;
        seed         = 32'hfe03d459;
        cycle        = 0;
        next_tag     = `MEM_TAG_W'(1);
        mem_rsp      = '0;
        accept_count = 0;
        forever begin
            @(negedge clock);
            cycle = cycle + 1;
            rsp   = '0;
            rnd   = $random(seed);
            busy  = ((rnd & 32'h7fff_ffff) % 100) < busy_pct;
            // a nonzero response tag takes a LOAD at the next edge
            // mem_req only moves at rising edges
            if (live && !busy) begin
                rsp.response = next_tag;
                if (mem_req.cmd == LOAD) begin
                    ret_tag.push_back(next_tag);
                    ret_addr.push_back(mem_req.addr);
                    ret_due.push_back(cycle + data_delay);
                    accept_count = accept_count + 1;
                    // rotate through nonzero tags
                    if (next_tag == {`MEM_TAG_W{1'b1}}) begin
                        next_tag = `MEM_TAG_W'(1);
                    end else begin
                        next_tag = next_tag + `MEM_TAG_W'(1);
                    end
                end
            end
            // data beat with the saved tag, lower word first
            if (ret_due.size() > 0 && ret_due[0] <= cycle) begin
                rsp.tag  = ret_tag[0];
                rsp.data = {mem_word(ret_addr[0] + 32'd4), mem_word(ret_addr[0])};
                void'(ret_tag.pop_front());
                void'(ret_addr.pop_front());
                void'(ret_due.pop_front());
            end
            mem_rsp = rsp;
        end
    end

endmodule

/* test/tb_fetch_top.sv */
`timescale 1ns/1ps
`include "fetch_settings.svh"

module tb_fetch_top;

    import fetch_pkg::*;

    // about five times the expected length of all tests
    localparam int cycle_limit = 4000;

    logic          clock;
    logic          arst_n;
    logic          stall;
    redirect_t     redirect;
    logic          warm;
    mem_req_t      mem_req;
    mem_rsp_t      mem_rsp;
    fetch_block_t  fetch_block;
    int            busy_pct;
    int            accept_count;
    integer        seed;

    // inputs as the dut took them at the last rising edge
    logic          stall_q;
    redirect_t     redirect_q;
    logic          warm_q;

    // checker state
    logic [`FETCH_XLEN-1:0]  exp_pc         = `FETCH_RESET_PC;
    logic [`FETCH_XLEN-1:0]  cur_target     = `FETCH_RESET_PC;
    fetch_block_t            prev_block     = '0;
    int                      since_redirect = 0;
    int                      target_loads   = 0;
    int                      errors         = 0;
    int                      stim_errors    = 0;
    int                      tests_failed   = 0;
    int                      cycles         = 0;

    tb_clock_gen u_clock_gen (
        .clock  (clock),
        .arst_n (arst_n)
    );

    tb_mem_model u_mem_model (
        .clock        (clock),
        .arst_n       (arst_n),
        .busy_pct     (busy_pct),
        .mem_req      (mem_req),
        .mem_rsp      (mem_rsp),
        .accept_count (accept_count)
    );

    fetch_top u_dut (
        .clock       (clock),
        .arst_n      (arst_n),
        .stall       (stall),
        .redirect    (redirect),
        .mem_rsp     (mem_rsp),
        .mem_req     (mem_req),
        .fetch_block (fetch_block)
    );

    // reference instruction word at byte address a
    function automatic logic [`FETCH_XLEN-1:0] expected_word(input logic [`FETCH_XLEN-1:0] a);
        return a ^ 32'h1357_9bdf;
    endfunction

    always @(posedge clock) begin
        stall_q    <= stall;
        redirect_q <= redirect;
        warm_q     <= warm;
    end

    ////////////////////////////////////////
    // compare on the falling edge
    ////////////////////////////////////////

    always @(negedge clock) begin
        if (redirect_q.valid) begin
            // sequence restarts at the target
            exp_pc         = redirect_q.target;
            cur_target     = redirect_q.target;
            since_redirect = 0;
            target_loads   = 0;
            if (fetch_block.valid) begin
                errors = errors + 1;
                $display("ERR fetch_block.valid got %h expected %h", fetch_block.valid, 1'b0);
            end
        end else if (stall_q) begin
            // output frozen
            if (fetch_block !== prev_block) begin
                errors = errors + 1;
                $display("ERR fetch_block got %h expected %h", fetch_block, prev_block);
            end
        end else if (fetch_block.valid) begin
            // a new block every edge without stall
            if (fetch_block.pc !== exp_pc) begin
                errors = errors + 1;
                $display("ERR fetch_block.pc got %h expected %h", fetch_block.pc, exp_pc);
            end
            if (fetch_block.inst[0] !== expected_word(exp_pc)) begin
                errors = errors + 1;
                $display("ERR fetch_block.inst[0] got %h expected %h",
                         fetch_block.inst[0], expected_word(exp_pc));
            end
            if (fetch_block.inst[1] !== expected_word(exp_pc + 32'd4)) begin
                errors = errors + 1;
                $display("ERR fetch_block.inst[1] got %h expected %h",
                         fetch_block.inst[1], expected_word(exp_pc + 32'd4));
            end
            exp_pc         = exp_pc + 32'd8;
            since_redirect = since_redirect + 1;
        end else if (warm_q && since_redirect < 16) begin
            // every warm pc hits so a block is due at each edge
            errors = errors + 1;
            $display("ERR fetch_block.valid got %h expected %h", fetch_block.valid, 1'b1);
        end
        if (mem_req.cmd == LOAD && mem_req.addr == cur_target) begin
            target_loads = target_loads + 1;
        end
        // warm pass hits everywhere
        if (warm_q && since_redirect < 16 && mem_req.cmd != NONE) begin
            errors = errors + 1;
            $display("ERR mem_req.cmd got %h expected %h", mem_req.cmd, NONE);
        end
        prev_block = fetch_block;
    end

    always @(posedge clock) begin
        cycles = cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("timeout after %0d cycles, the tests did not finish", cycles);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    ////////////////////////////////////////
    // stimulus tasks
    ////////////////////////////////////////

    task automatic redirect_to(input logic [`FETCH_XLEN-1:0] target, input logic warm_pass);
        @(negedge clock);
        redirect.valid  = 1'b1;
        redirect.target = target;
        warm            = warm_pass;
        @(negedge clock);
        redirect        = '0;
    endtask

    // blocks counted since the last redirect
    task automatic wait_blocks(input int n);
        do @(posedge clock); while (since_redirect < n);
    endtask

    task automatic fetch_cold(input logic [`FETCH_XLEN-1:0] addr);
        redirect_to(addr, 1'b0);
        wait_blocks(1);
        if (target_loads == 0) begin
            stim_errors = stim_errors + 1;
            $display("no LOAD was issued for block %h before it was delivered", addr);
        end
    endtask

    task automatic report_test(input int num, input string name, input int mark);
        int total;
        total = errors + stim_errors;
        if (total == mark) begin
            $display("test %0d %s: ok", num, name);
        end else begin
            tests_failed = tests_failed + 1;
            $display("test %0d %s: %0d errors", num, name, total - mark);
        end
    endtask

    initial begin : stimulus
        int mark;
        int acc;
        int base;
        int stall_cycles;
        seed         = 32'hfe03d459;
        stall        = 1'b0;
        redirect     = '0;
        warm         = 1'b0;
        busy_pct     = 25;
        stall_cycles = 0;

        // cold fetch from reset
        mark = 0;
        wait_blocks(16);
        report_test(1, "cold sequential fetch", mark);

        // same 16 blocks again, all hits
        mark = errors + stim_errors;
        redirect_to(32'h0000_0000, 1'b1);
        wait_blocks(4);
        // restart while the current pc hits so a ready packet is dropped
        redirect_to(32'h0000_0000, 1'b1);
        wait_blocks(16);
        @(negedge clock);
        warm = 1'b0;
        @(posedge clock);
        report_test(2, "warm loop", mark);

        // redirect right after memory took a LOAD
        mark = errors + stim_errors;
        acc  = accept_count;
        do @(posedge clock); while (accept_count == acc);
        redirect_to(32'h0000_0400, 1'b0);
        wait_blocks(8);
        report_test(3, "redirect during a miss", mark);

        // random stall pulses
        mark = errors + stim_errors;
        base = since_redirect;
        while (since_redirect < base + 16) begin
            @(negedge clock);
            stall = ($random(seed) & 32'h3) == 32'h0;
            if (stall) begin
                stall_cycles = stall_cycles + 1;
            end
            @(posedge clock);
        end
        @(negedge clock);
        stall = 1'b0;
        @(posedge clock);
        if (stall_cycles == 0) begin
            stim_errors = stim_errors + 1;
            $display("the stall test drove no stall cycle");
        end
        report_test(4, "stall", mark);

        // same index, different tag
        mark = errors + stim_errors;
        fetch_cold(32'h0000_0000);
        fetch_cold(32'h0000_0100);
        fetch_cold(32'h0000_0000);
        report_test(5, "conflict eviction", mark);

        // memory mostly busy
        mark     = errors + stim_errors;
        busy_pct = 80;
        redirect_to(32'h0000_0800, 1'b0);
        wait_blocks(16);
        busy_pct = 25;
        report_test(6, "busy memory", mark);

        $display("tests run 6, tests failed %0d, errors %0d", tests_failed,
                 errors + stim_errors);
        if (tests_failed == 0 && errors + stim_errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

/* fetch_top.f */
+incdir+logic
logic/fetch_pkg.sv
logic/icache_mem.sv
logic/icache_ctrl.sv
logic/fetch_stage.sv
logic/fetch_top.sv
test/tb_clock_gen.sv
test/tb_mem_model.sv
test/tb_fetch_top.sv

/* run_sim.sh */
#!/bin/sh
# compile and run the fetch front end testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps \
    --top-module tb_fetch_top -Mdir obj_dir -f fetch_top.f
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

./obj_dir/Vtb_fetch_top > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^Simulation finished: PASS$" sim.log; then
    exit 0
fi
echo "pass message not found in sim.log"
exit 1
